// ==== hdl/ahb_matrix_pkg.sv ====
// AHB bus matrix common types
package ahb_matrix_pkg;

  // --------------------------------------------------
  // Field widths and types
  // --------------------------------------------------
  localparam int ADDR_WIDTH = 32;             // HADDR width

  typedef enum logic [1:0]
  {
    TRANS_IDLE   = 2'b00,                     // No transfer
    TRANS_BUSY   = 2'b01,                     // Burst paused by master
    TRANS_NONSEQ = 2'b10,                     // First beat or single
    TRANS_SEQ    = 2'b11                      // Remaining burst beats
  } trans_t;

  typedef logic [2:0] size_t;                 // HSIZE
  typedef logic [2:0] burst_t;                // HBURST, passed through as is
  typedef logic [3:0] prot_t;                 // HPROT
  typedef logic [3:0] master_t;               // HMASTER id

  // --------------------------------------------------
  // One address/control phase
  // --------------------------------------------------
  typedef struct packed
  {
    logic                  sel;               // HSEL for this slave
    logic [ADDR_WIDTH-1:0] addr;              // HADDR
    trans_t                trans;             // HTRANS
    logic                  write;             // HWRITE, 1 for write
    size_t                 size;              // HSIZE
    burst_t                burst;             // HBURST
    prot_t                 prot;              // HPROT
    master_t               master;            // HMASTER
    logic                  mastlock;          // HMASTLOCK
  } ahb_addr_ctrl_t;

  // Bit 1 of HTRANS marks NONSEQ or SEQ, a real transfer
  localparam int TRANS_ACTIVE_BIT = 1;

endpackage

// ==== hdl/ahb_output_arbiter.sv ====
// Round-robin output arbiter
module ahb_output_arbiter #(
  parameter  int NUM_PORTS = 4,
  localparam int PORT_W    = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
  input  logic                           HCLK,            // AHB clock
  input  logic                           HRESETn,         // Sync reset, active low
  input  logic [NUM_PORTS-1:0]           i_req,           // Held transfer and sel per port
  input  logic                           i_hready,        // Muxed HREADY, update enable
  input  ahb_matrix_pkg::ahb_addr_ctrl_t i_slave_ac,      // Phase currently on the slave
  output logic [PORT_W-1:0]              o_addr_in_port,  // Granted port index
  output logic                           o_no_port        // No port granted
);

  import ahb_matrix_pkg::*;

  logic [PORT_W-1:0] addr_in_port;    // Grant register
  logic              no_port;         // Idle flag register
  logic [PORT_W-1:0] next_port;       // Grant for next ready edge
  logic              next_no_port;    // Idle flag for next ready edge

  logic              hsel_lock;       // Lock seen while selected
  logic              next_hsel_lock;  // Pre-registered hsel_lock
  logic              hlock_arb;       // Mastlock as seen by arbitration
  logic              burst_hold;      // SEQ or BUSY on the granted port
  logic              hold_grant;      // Keep current grant

  // --------------------------------------------------
  // Lock tracking
  // --------------------------------------------------
  // A master may leave sel low in the middle of a locked sequence while
  // it talks to another slave, so the lock is remembered here
  assign next_hsel_lock = (i_slave_ac.sel && i_slave_ac.trans[TRANS_ACTIVE_BIT] &&
                           i_slave_ac.mastlock) ? 1'b1 :
                          (!i_slave_ac.mastlock)  ? 1'b0 :
                          hsel_lock;                      // Otherwise hold

  assign hlock_arb  = i_slave_ac.mastlock & (hsel_lock | i_slave_ac.sel);
  assign burst_hold = i_slave_ac.sel &
                      ((i_slave_ac.trans == TRANS_SEQ) | (i_slave_ac.trans == TRANS_BUSY));
  assign hold_grant = hlock_arb | burst_hold;

  // --------------------------------------------------
  // Next grant
  // --------------------------------------------------
  always_comb
  begin : p_next_grant
    int unsigned cand;                                    // Candidate port
    logic        found;                                   // Request seen
    next_port    = addr_in_port;                          // Default keep index
    next_no_port = no_port;
    found        = 1'b0;
    cand         = 0;
    if (!hold_grant)
    begin
      // Search starts after current index, current one comes last
      for (int i = 1; i <= NUM_PORTS; i++)
      begin
        cand = (int'(addr_in_port) + i) % NUM_PORTS;
        if (!found && i_req[cand])
        begin
          next_port = PORT_W'(cand);
          found     = 1'b1;
        end
      end
      next_no_port = !found;                              // Idle when nobody asks
    end
  end

  // Registers move only on a ready edge
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      addr_in_port <= '0;
      no_port      <= 1'b1;
      hsel_lock    <= 1'b0;
    end
    else if (i_hready)
    begin
      addr_in_port <= next_port;
      no_port      <= next_no_port;
      hsel_lock    <= next_hsel_lock;
    end
  end

  assign o_addr_in_port = addr_in_port;
  assign o_no_port      = no_port;

endmodule

// ==== hdl/ahb_addr_mux.sv ====
// Address and control multiplexer
module ahb_addr_mux #(
  parameter  int NUM_PORTS = 4,
  localparam int PORT_W    = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
  input  ahb_matrix_pkg::ahb_addr_ctrl_t i_port_ac [NUM_PORTS],  // Held phase per port
  input  logic [PORT_W-1:0]              i_addr_in_port,         // Granted port index
  input  logic                           i_no_port,              // No port granted
  output ahb_matrix_pkg::ahb_addr_ctrl_t o_slave_ac,             // Phase to the slave
  output logic [NUM_PORTS-1:0]           o_active                // Port is being served
);

  // --------------------------------------------------
  // Address phase select
  // --------------------------------------------------
  // Whole struct moves as one, HBURST included untouched
  always_comb
  begin : p_addr_mux
    o_slave_ac = '0;                                     // Idle phase, sel low
    if (!i_no_port)
    begin
      o_slave_ac = i_port_ac[i_addr_in_port];            // Granted port
    end
  end

  // --------------------------------------------------
  // Active strobes
  // --------------------------------------------------
  // One-hot back to the input stages, zero when idle
  always_comb
  begin : p_active_dec
    o_active = '0;
    if (!i_no_port)
    begin
      o_active[i_addr_in_port] = 1'b1;                   // Served port only
    end
  end

endmodule

// ==== hdl/ahb_data_phase.sv ====
// Data phase steering and HREADY mux
module ahb_data_phase #(
  parameter  int NUM_PORTS  = 4,
  parameter  int DATA_WIDTH = 32,
  localparam int PORT_W     = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
  input  logic                  HCLK,                          // AHB clock
  input  logic                  HRESETn,                       // Sync reset, active low
  input  logic [DATA_WIDTH-1:0] i_port_wdata [NUM_PORTS],      // Write data per port
  input  logic [PORT_W-1:0]     i_addr_in_port,                // Address phase owner
  input  logic                  i_slave_sel,                   // HSEL of muxed phase
  input  logic                  i_hreadyout,                   // Slave HREADYOUT
  output logic [DATA_WIDTH-1:0] o_hwdata,                      // Write data to slave
  output logic                  o_hreadymux                    // Muxed HREADY
);

  logic [PORT_W-1:0] data_in_port;    // Data phase owner
  logic              slave_sel;       // Slave owns data phase
  logic              hready;          // Internal muxed HREADY

  // --------------------------------------------------
  // Data phase registers
  // --------------------------------------------------
  // Address phase owner becomes data phase owner on each ready edge
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      data_in_port <= '0;
      slave_sel    <= 1'b0;
    end
    else if (hready)
    begin
      data_in_port <= i_addr_in_port;                // Follows grant by one edge
      slave_sel    <= i_slave_sel;
    end
  end

  // Write data from data phase owner
  assign o_hwdata = i_port_wdata[data_in_port];

  // --------------------------------------------------
  // HREADY generation
  // --------------------------------------------------
  // Slave drives HREADY only for a data phase it was selected for,
  // otherwise the stage is always ready
  assign hready      = slave_sel ? i_hreadyout : 1'b1;
  assign o_hreadymux = hready;

endmodule

// ==== hdl/ahb_output_stage.sv ====
// AHB matrix output stage
module ahb_output_stage #(
  parameter int NUM_PORTS  = 4,
  parameter int DATA_WIDTH = 32
) (
  input  logic                           HCLK,                      // AHB clock
  input  logic                           HRESETn,                   // Sync reset, active low
  input  ahb_matrix_pkg::ahb_addr_ctrl_t i_port_ac [NUM_PORTS],     // Held phase per port
  input  logic [DATA_WIDTH-1:0]          i_port_wdata [NUM_PORTS],  // Write data per port
  input  logic [NUM_PORTS-1:0]           i_held_tran,               // Port holds a transfer
  input  logic                           i_hreadyout,               // Slave HREADYOUT
  output logic [NUM_PORTS-1:0]           o_active,                  // Port is being served
  output ahb_matrix_pkg::ahb_addr_ctrl_t o_slave_ac,                // Phase to the slave
  output logic                           o_hreadymux,               // Muxed HREADY
  output logic [DATA_WIDTH-1:0]          o_hwdata                   // Write data to slave
);

  localparam int PORT_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

  logic [NUM_PORTS-1:0] req;            // Arbitration requests
  logic [PORT_W-1:0]    addr_in_port;   // Grant index
  logic                 no_port;        // Nothing granted

  // --------------------------------------------------
  // Requests
  // --------------------------------------------------
  always_comb
  begin : p_req
    for (int i = 0; i < NUM_PORTS; i++)
    begin
      req[i] = i_held_tran[i] & i_port_ac[i].sel;  // Held and addressed here
    end
  end

  // --------------------------------------------------
  // Blocks
  // --------------------------------------------------
  ahb_output_arbiter #(
    .NUM_PORTS (NUM_PORTS)
  ) u_output_arb (
    .HCLK           (HCLK),
    .HRESETn        (HRESETn),
    .i_req          (req),
    .i_hready       (o_hreadymux),                  // Update only on ready edge
    .i_slave_ac     (o_slave_ac),                   // Burst and lock holds
    .o_addr_in_port (addr_in_port),
    .o_no_port      (no_port)
  );

  ahb_addr_mux #(
    .NUM_PORTS (NUM_PORTS)
  ) u_addr_mux (
    .i_port_ac      (i_port_ac),
    .i_addr_in_port (addr_in_port),
    .i_no_port      (no_port),
    .o_slave_ac     (o_slave_ac),
    .o_active       (o_active)
  );

  ahb_data_phase #(
    .NUM_PORTS  (NUM_PORTS),
    .DATA_WIDTH (DATA_WIDTH)
  ) u_data_phase (
    .HCLK           (HCLK),
    .HRESETn        (HRESETn),
    .i_port_wdata   (i_port_wdata),
    .i_addr_in_port (addr_in_port),
    .i_slave_sel    (o_slave_ac.sel),               // Slave owns next data phase
    .i_hreadyout    (i_hreadyout),
    .o_hwdata       (o_hwdata),
    .o_hreadymux    (o_hreadymux)
  );

endmodule

// ==== verification/tb_clock_gen.sv ====
// Testbench clock and reset
module tb_clock_gen #(
  parameter int PERIOD       = 8,       // HCLK period
  parameter int RESET_CYCLES = 4        // Cycles with HRESETn low
) (
  output logic o_hclk,                  // AHB clock
  output logic o_hresetn                // Sync reset, active low
);

  initial
  begin
    o_hclk = 1'b0;
    forever #(PERIOD / 2) o_hclk = ~o_hclk;
  end

  initial
  begin
    o_hresetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_hclk);
    @(negedge o_hclk);                  // Release away from the active edge
    o_hresetn = 1'b1;
  end

endmodule

// ==== verification/ahb_output_stage_checker.sv ====
// Output stage assertions
module ahb_output_stage_checker #(
  parameter  int NUM_PORTS = 4,
  localparam int PORT_W    = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1
) (
  input logic                 HCLK,            // AHB clock
  input logic                 HRESETn,         // Sync reset, active low
  input logic [NUM_PORTS-1:0] i_active,        // Active strobes
  input logic                 i_slave_sel,     // HSEL of muxed phase
  input logic                 i_hreadymux,     // Muxed HREADY
  input logic [PORT_W-1:0]    i_addr_in_port,  // Grant index
  input logic                 i_no_port        // Nothing granted
);

  int unsigned fail_count = 0;                 // Assertion failures so far

  // At most one input stage served at a time
  a_active_onehot : assert property (@(posedge HCLK) disable iff (!HRESETn)
    $onehot0(i_active))
    else
    begin
      $error("o_active has more than one port set");
      fail_count++;
    end

  // Data phase without the slave never stalls
  a_ready_after_unsel : assert property (@(posedge HCLK) disable iff (!HRESETn)
    (i_hreadymux && !i_slave_sel) |=> i_hreadymux)
    else
    begin
      $error("o_hreadymux low after a ready edge with sel low");
      fail_count++;
    end

  // Back-pressure freezes the grant
  a_grant_frozen : assert property (@(posedge HCLK) disable iff (!HRESETn)
    !i_hreadymux |=> ($stable(i_addr_in_port) && $stable(i_no_port)))
    else
    begin
      $error("Grant changed while o_hreadymux was low");
      fail_count++;
    end

endmodule

bind ahb_output_stage ahb_output_stage_checker #(
  .NUM_PORTS (NUM_PORTS)
) u_checker (
  .HCLK           (HCLK),
  .HRESETn        (HRESETn),
  .i_active       (o_active),
  .i_slave_sel    (o_slave_ac.sel),
  .i_hreadymux    (o_hreadymux),
  .i_addr_in_port (addr_in_port),
  .i_no_port      (no_port)
);

// ==== verification/ahb_output_stage_tb.sv ====
// Output stage testbench
module ahb_output_stage_tb;

  import ahb_matrix_pkg::*;

  localparam int NUM_PORTS    = 4;
  localparam int DATA_WIDTH   = 32;
  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 4;
  localparam int RESET_TEST   = 2;     // Cycle budget per test
  localparam int RR_TEST      = 10;
  localparam int SINGLE_TEST  = 4;
  localparam int HOLD_TEST    = 14;
  localparam int DATA_TEST    = 10;
  localparam int MARGIN       = 20;
  localparam int RUN_CYCLES   = RESET_CYCLES + RESET_TEST + RR_TEST + SINGLE_TEST +
                                HOLD_TEST + DATA_TEST + MARGIN;

  logic                  HCLK;
  logic                  HRESETn;
  ahb_addr_ctrl_t        port_ac [NUM_PORTS];      // Held phase per port
  logic [DATA_WIDTH-1:0] port_wdata [NUM_PORTS];   // Write data per port
  logic [NUM_PORTS-1:0]  held_tran;
  logic                  hreadyout;                // Slave HREADYOUT
  logic [NUM_PORTS-1:0]  active;
  ahb_addr_ctrl_t        slave_ac;
  logic                  hreadymux;
  logic [DATA_WIDTH-1:0] hwdata;
  logic [15:0]           lfsr      = 16'd41690;    // Stimulus LFSR state

  tb_clock_gen #(
    .PERIOD       (CLK_PERIOD),
    .RESET_CYCLES (RESET_CYCLES)
  ) u_clock_gen (
    .o_hclk    (HCLK),
    .o_hresetn (HRESETn)
  );

  ahb_output_stage uut (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .i_port_ac    (port_ac),
    .i_port_wdata (port_wdata),
    .i_held_tran  (held_tran),
    .i_hreadyout  (hreadyout),
    .o_active     (active),
    .o_slave_ac   (slave_ac),
    .o_hreadymux  (hreadymux),
    .o_hwdata     (hwdata)
  );

  // --------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------
  function automatic logic lfsr_step();
    logic fb;
    fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];  // x^16+x^14+x^13+x^11
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v = {v[30:0], lfsr_step()};                    // One step per bit
    return v;
  endfunction

  function automatic ahb_addr_ctrl_t make_ac(input int port, input trans_t trans);
    ahb_addr_ctrl_t ac;
    ac        = '0;
    ac.sel    = 1'b1;
    ac.addr   = rand_bits(ADDR_WIDTH);
    ac.trans  = trans;
    ac.write  = 1'(rand_bits(1));
    ac.size   = size_t'(rand_bits(2));               // Byte to doubleword
    ac.burst  = burst_t'(rand_bits(3));
    ac.prot   = prot_t'(rand_bits(4));
    ac.master = master_t'(port);
    return ac;
  endfunction

  task automatic drive_idle();
    for (int p = 0; p < NUM_PORTS; p++)
      port_ac[p] = '0;
    held_tran = '0;
  endtask

  // --------------------------------------------------
  // Compare tasks
  // --------------------------------------------------
  task automatic abort_run();
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_ac(input string name, input ahb_addr_ctrl_t exp, input ahb_addr_ctrl_t act);
    if (act !== exp)
    begin
      $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_active(input string name, input logic [NUM_PORTS-1:0] exp,
                              input logic [NUM_PORTS-1:0] act);
    if (act !== exp)
    begin
      $display("Error at %0t: %s expected %b, got %b", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_word(input string name, input logic [DATA_WIDTH-1:0] exp,
                            input logic [DATA_WIDTH-1:0] act);
    if (act !== exp)
    begin
      $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("Error at %0t: %s expected %b, got %b", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic expect_grant(input int p);
    logic [NUM_PORTS-1:0] onehot;
    onehot    = '0;
    onehot[p] = 1'b1;
    check_active("o_active", onehot, active);
    check_ac("o_slave_ac", port_ac[p], slave_ac);     // Whole phase, burst included
  endtask

  task automatic settle_idle();
    drive_idle();
    repeat (2) @(negedge HCLK);
    check_active("o_active", '0, active);
    check_ac("o_slave_ac", '0, slave_ac);
  endtask

  // --------------------------------------------------
  // Directed tests
  // --------------------------------------------------
  task automatic test_reset_state();
    @(negedge HCLK);
    check_active("o_active", '0, active);
    check_ac("o_slave_ac", '0, slave_ac);
    check_bit("o_hreadymux", 1'b1, hreadymux);
    check_word("o_hwdata", port_wdata[0], hwdata);    // Port 0 after reset
  endtask

  task automatic test_round_robin();
    int exp_seq [6];
    exp_seq    = '{1, 3, 0, 1, 3, 0};                  // Index 0 is the start point
    port_ac[0] = make_ac(0, TRANS_NONSEQ);
    port_ac[1] = make_ac(1, TRANS_NONSEQ);
    port_ac[3] = make_ac(3, TRANS_NONSEQ);
    held_tran  = 4'b1011;
    foreach (exp_seq[k])
    begin
      @(negedge HCLK);
      expect_grant(exp_seq[k]);
    end
    settle_idle();
  endtask

  task automatic test_single_request();
    port_ac[2]   = make_ac(2, TRANS_NONSEQ);
    held_tran[2] = 1'b1;
    @(negedge HCLK);
    expect_grant(2);
    held_tran[2] = 1'b0;                               // Phase stays, request goes
    @(negedge HCLK);
    check_active("o_active", '0, active);
    check_ac("o_slave_ac", '0, slave_ac);
  endtask

  task automatic test_burst_lock_hold();
    port_ac[1] = make_ac(1, TRANS_NONSEQ);
    held_tran  = 4'b0010;
    @(negedge HCLK);
    expect_grant(1);
    port_ac[1].trans = TRANS_SEQ;                      // Burst continues
    port_ac[0]       = make_ac(0, TRANS_NONSEQ);
    port_ac[3]       = make_ac(3, TRANS_NONSEQ);
    held_tran        = 4'b1011;
    repeat (3)
    begin
      @(negedge HCLK);
      expect_grant(1);
      port_ac[1].addr += 4;
    end
    port_ac[1].trans = TRANS_IDLE;
    held_tran[1]     = 1'b0;
    @(negedge HCLK);
    expect_grant(3);
    port_ac[3].mastlock = 1'b1;                        // Locked sequence starts
    @(negedge HCLK);
    expect_grant(3);
    port_ac[3].sel = 1'b0;                             // Master away, lock held
    repeat (2)
    begin
      @(negedge HCLK);
      expect_grant(3);
    end
    port_ac[3].mastlock = 1'b0;
    @(negedge HCLK);
    expect_grant(0);
    settle_idle();
  endtask

  task automatic test_data_backpressure();
    port_ac[1]       = make_ac(1, TRANS_NONSEQ);
    port_ac[1].write = 1'b1;
    held_tran        = 4'b0010;
    @(negedge HCLK);
    expect_grant(1);
    check_bit("o_hreadymux", 1'b1, hreadymux);
    port_ac[2] = make_ac(2, TRANS_NONSEQ);
    held_tran  = 4'b0100;
    @(negedge HCLK);
    expect_grant(2);
    check_word("o_hwdata", port_wdata[1], hwdata);    // Port 1 data phase
    check_bit("o_hreadymux", 1'b1, hreadymux);
    hreadyout  = 1'b0;                                 // Slave stalls
    port_ac[3] = make_ac(3, TRANS_NONSEQ);
    held_tran  = 4'b1100;
    repeat (2)
    begin
      @(negedge HCLK);
      check_bit("o_hreadymux", 1'b0, hreadymux);
      expect_grant(2);
      check_word("o_hwdata", port_wdata[1], hwdata);
    end
    hreadyout = 1'b1;
    @(negedge HCLK);
    expect_grant(3);
    check_word("o_hwdata", port_wdata[2], hwdata);
    check_bit("o_hreadymux", 1'b1, hreadymux);
    settle_idle();
  endtask

  // --------------------------------------------------
  // Run control
  // --------------------------------------------------
  initial
  begin
    #(RUN_CYCLES * CLK_PERIOD);
    $display("Timeout: tests did not finish within %0d cycles", RUN_CYCLES);
    abort_run();
  end

  initial
  begin
    drive_idle();
    hreadyout = 1'b1;
    for (int p = 0; p < NUM_PORTS; p++)
      port_wdata[p] = rand_bits(DATA_WIDTH);
    wait (HRESETn === 1'b1);
    test_reset_state();
    test_round_robin();
    test_single_request();
    test_burst_lock_hold();
    test_data_backpressure();
    if (uut.u_checker.fail_count == 0)
    begin
      $display("Verification passed");
      $finish;
    end
    else
    begin
      $display("Assertions failed %0d times", uut.u_checker.fail_count);
      abort_run();
    end
  end

endmodule

// ==== filelist.f ====
hdl/ahb_matrix_pkg.sv
hdl/ahb_output_arbiter.sv
hdl/ahb_addr_mux.sv
hdl/ahb_data_phase.sv
hdl/ahb_output_stage.sv
verification/tb_clock_gen.sv
verification/ahb_output_stage_checker.sv
verification/ahb_output_stage_tb.sv

// ==== Bender.yml ====
package:
  name: ahb_output_stage

sources:
  - files:
      - hdl/ahb_matrix_pkg.sv
      - hdl/ahb_output_arbiter.sv
      - hdl/ahb_addr_mux.sv
      - hdl/ahb_data_phase.sv
      - hdl/ahb_output_stage.sv
  - target: simulation
    files:
      - verification/tb_clock_gen.sv
      - verification/ahb_output_stage_checker.sv
      - verification/ahb_output_stage_tb.sv
